// ==== hdl/rv_decode_pkg.sv ====
// RV32I decoder shared types
// Instruction fields, classes and stage controls

package rv_decode_pkg;

    localparam int REG_ADDR_W_MAX = 5; // Full register index width

    // Base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [REG_ADDR_W_MAX-1:0] rs2;
        logic [REG_ADDR_W_MAX-1:0] rs1;
        logic [2:0]                funct3;
        logic [REG_ADDR_W_MAX-1:0] rd;
        logic [6:0]                opcode;
    } instr_fields_t;

    typedef enum logic [3:0] {
        OP,
        OPIMM,
        LOAD,
        STORE,
        AUIPC,
        BRANCH,
        JAL,
        JALR,
        LUI,
        ILLEGAL
    } opclass_e;

    typedef enum logic {ALU_A_RS1, ALU_A_PC} alu_a_e;
    typedef enum logic {ALU_B_RS2, ALU_B_IMM} alu_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM, WB_NPC} wb_src_e;
    typedef enum logic [1:0] {PC_NPC, PC_JALR_TARGET, PC_PC_REL, PC_BRANCH_COND} pc_src_e;

    typedef struct packed {
        logic                      enable;
        logic [REG_ADDR_W_MAX-1:0] rs1;
        logic [REG_ADDR_W_MAX-1:0] rs2;
    } rf_read_t;

    typedef struct packed {
        logic       enable;
        logic       branch;
        logic       alt;    // SUB or SRA/SRAI
        logic [2:0] op;     // funct3, 0 is add
    } alu_ctrl_t;

    typedef struct packed {
        logic       enable;
        logic       store;
        logic [2:0] width; // funct3 size code
    } mem_ctrl_t;

    typedef struct packed {
        logic                      enable;
        logic [REG_ADDR_W_MAX-1:0] rd;
    } wb_ctrl_t;

    typedef struct packed {
        alu_a_e  alu_a;
        alu_b_e  alu_b;
        wb_src_e wb_src;
        pc_src_e pc_src;
    } mux_sel_t;

endpackage

// ==== hdl/opcode_classifier.sv ====
// Opcode to instruction class

`timescale 1ns/1ps

module opcode_classifier (
    input  rv_decode_pkg::instr_fields_t instr,
    output rv_decode_pkg::opclass_e      opclass
);

    always_comb begin
        case (instr.opcode)
            rv_decode_pkg::OPC_LUI:    opclass = rv_decode_pkg::LUI;
            rv_decode_pkg::OPC_AUIPC:  opclass = rv_decode_pkg::AUIPC;
            rv_decode_pkg::OPC_JAL:    opclass = rv_decode_pkg::JAL;
            rv_decode_pkg::OPC_JALR:   opclass = rv_decode_pkg::JALR;
            rv_decode_pkg::OPC_BRANCH: opclass = rv_decode_pkg::BRANCH;
            rv_decode_pkg::OPC_LOAD:   opclass = rv_decode_pkg::LOAD;
            rv_decode_pkg::OPC_STORE:  opclass = rv_decode_pkg::STORE;
            rv_decode_pkg::OPC_OPIMM:  opclass = rv_decode_pkg::OPIMM;
            rv_decode_pkg::OPC_OP:     opclass = rv_decode_pkg::OP;
            default:                   opclass = rv_decode_pkg::ILLEGAL; // SYSTEM, FENCE too
        endcase

        // Compressed space never maps to a base class
        if (instr.opcode[1:0] != 2'b11) begin
            assert (opclass == rv_decode_pkg::ILLEGAL)
                else $error("opcode %b classified as %s", instr.opcode, opclass.name());
        end
    end

endmodule

// ==== hdl/field_validator.sv ====
// Field legality check and fault register

`timescale 1ns/1ps

module field_validator #(
    parameter int REG_ADDR_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_decode_pkg::instr_fields_t instr,
    input  rv_decode_pkg::opclass_e      opclass,
    output logic                         fault
);

    logic bad_class;
    logic bad_funct3;
    logic bad_funct7;
    logic bad_reg;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic rs1_oor;
    logic rs2_oor;
    logic rd_oor;

    // Index not below 2**REG_ADDR_W
    assign rs1_oor = (32'(instr.rs1) >> REG_ADDR_W) != 0;
    assign rs2_oor = (32'(instr.rs2) >> REG_ADDR_W) != 0;
    assign rd_oor  = (32'(instr.rd) >> REG_ADDR_W) != 0;

    always_comb begin
        bad_class  = 1'b0;
        bad_funct3 = 1'b0;
        bad_funct7 = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        uses_rd    = 1'b1;
        case (opclass)
            rv_decode_pkg::STORE: begin
                bad_funct3 = instr.funct3 > 3'd2;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                uses_rd    = 1'b0;
            end
            rv_decode_pkg::LOAD: begin
                bad_funct3 = instr.funct3 inside {3'd3, 3'd6, 3'd7};
                uses_rs1   = 1'b1;
            end
            rv_decode_pkg::BRANCH: begin
                bad_funct3 = instr.funct3 inside {3'd2, 3'd3};
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                uses_rd    = 1'b0;
            end
            rv_decode_pkg::JALR: begin
                bad_funct3 = instr.funct3 != 3'd0;
                uses_rs1   = 1'b1;
            end
            rv_decode_pkg::OP: begin
                // Only SUB and SRA take the alternate encoding
                bad_funct7 = !(instr.funct7 == 7'h00 ||
                               (instr.funct7 == 7'h20 && instr.funct3 inside {3'd0, 3'd5}));
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
            end
            rv_decode_pkg::OPIMM: begin
                if (instr.funct3 == 3'd1) begin
                    bad_funct7 = instr.funct7 != 7'h00; // SLLI
                end else if (instr.funct3 == 3'd5) begin
                    bad_funct7 = !(instr.funct7 inside {7'h00, 7'h20}); // SRLI, SRAI
                end
                uses_rs1 = 1'b1;
            end
            rv_decode_pkg::ILLEGAL: bad_class = 1'b1;
            default: ;                                  // LUI, AUIPC, JAL
        endcase
    end

    assign bad_reg = (uses_rs1 && rs1_oor) || (uses_rs2 && rs2_oor) || (uses_rd && rd_oor);

    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= 1'b0;
        end else begin
            fault <= bad_class || bad_funct3 || bad_funct7 || bad_reg;
        end
    end

    // Unknown opcode must surface as a fault on the next cycle
    illegal_faults: assert property (@(posedge clk) disable iff (rst)
        opclass == rv_decode_pkg::ILLEGAL |=> fault)
        else $error("illegal class without fault");

endmodule

// ==== hdl/imm_generator.sv ====
// Immediate assembly per instruction format

`timescale 1ns/1ps

module imm_generator (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_decode_pkg::instr_fields_t instr,
    input  rv_decode_pkg::opclass_e      opclass,
    output logic [31:0]                  imm
);

    logic [31:0] w;
    logic [31:0] imm_next;

    assign w = instr;

    always_comb begin
        case (opclass)
            rv_decode_pkg::LUI,
            rv_decode_pkg::AUIPC: begin
                imm_next = {w[31:12], 12'b0};                                   // U
            end
            rv_decode_pkg::JAL: begin
                imm_next = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};      // J
            end
            rv_decode_pkg::BRANCH: begin
                imm_next = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};        // B
            end
            rv_decode_pkg::STORE: begin
                imm_next = {{20{w[31]}}, w[31:25], w[11:7]};                    // S
            end
            default: begin
                imm_next = {{20{w[31]}}, w[31:20]};                             // I
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            imm <= '0;
        end else begin
            imm <= imm_next;
        end
    end

endmodule

// ==== hdl/microcode_encoder.sv ====
// Per-stage control words and mux selects

`timescale 1ns/1ps

module microcode_encoder (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_decode_pkg::instr_fields_t instr,
    input  rv_decode_pkg::opclass_e      opclass,
    output rv_decode_pkg::rf_read_t      rf_read,
    output rv_decode_pkg::alu_ctrl_t     alu_ctrl,
    output rv_decode_pkg::mem_ctrl_t     mem_ctrl,
    output rv_decode_pkg::wb_ctrl_t      wb_ctrl,
    output rv_decode_pkg::mux_sel_t      mux_sel
);

    rv_decode_pkg::rf_read_t  rf_read_next;
    rv_decode_pkg::alu_ctrl_t alu_ctrl_next;
    rv_decode_pkg::mem_ctrl_t mem_ctrl_next;
    rv_decode_pkg::wb_ctrl_t  wb_ctrl_next;
    rv_decode_pkg::mux_sel_t  mux_sel_next;
    logic                     is_op;
    logic                     is_opimm;
    logic                     alt_ok;

    assign is_op    = opclass == rv_decode_pkg::OP;
    assign is_opimm = opclass == rv_decode_pkg::OPIMM;
    // ADD/SUB, SRL/SRA and SRLI/SRAI carry funct7[5]
    assign alt_ok   = (is_op && instr.funct3 inside {3'd0, 3'd5}) ||
                      (is_opimm && instr.funct3 == 3'd5);

    always_comb begin
        rf_read_next.enable = opclass inside {rv_decode_pkg::JALR, rv_decode_pkg::BRANCH,
                                              rv_decode_pkg::LOAD, rv_decode_pkg::STORE,
                                              rv_decode_pkg::OP, rv_decode_pkg::OPIMM};
        rf_read_next.rs1    = instr.rs1;
        rf_read_next.rs2    = instr.rs2;

        alu_ctrl_next.enable = opclass inside {rv_decode_pkg::OP, rv_decode_pkg::OPIMM,
                                               rv_decode_pkg::BRANCH, rv_decode_pkg::LOAD,
                                               rv_decode_pkg::STORE, rv_decode_pkg::AUIPC,
                                               rv_decode_pkg::JALR};
        alu_ctrl_next.branch = opclass == rv_decode_pkg::BRANCH;
        alu_ctrl_next.alt    = alt_ok && instr.funct7[5];
        alu_ctrl_next.op     = (is_op || is_opimm || alu_ctrl_next.branch) ? instr.funct3 : 3'd0;

        mem_ctrl_next.enable = opclass inside {rv_decode_pkg::LOAD, rv_decode_pkg::STORE};
        mem_ctrl_next.store  = opclass == rv_decode_pkg::STORE;
        mem_ctrl_next.width  = instr.funct3;

        wb_ctrl_next.enable = !(opclass inside {rv_decode_pkg::STORE, rv_decode_pkg::BRANCH,
                                                rv_decode_pkg::ILLEGAL});
        wb_ctrl_next.rd     = instr.rd;

        mux_sel_next.alu_a = (opclass == rv_decode_pkg::AUIPC) ? rv_decode_pkg::ALU_A_PC
                                                               : rv_decode_pkg::ALU_A_RS1;
        mux_sel_next.alu_b = (is_op || alu_ctrl_next.branch) ? rv_decode_pkg::ALU_B_RS2
                                                             : rv_decode_pkg::ALU_B_IMM;
        case (opclass)
            rv_decode_pkg::LOAD: mux_sel_next.wb_src = rv_decode_pkg::WB_MEM;
            rv_decode_pkg::JAL,
            rv_decode_pkg::JALR: mux_sel_next.wb_src = rv_decode_pkg::WB_NPC; // Link address
            rv_decode_pkg::LUI:  mux_sel_next.wb_src = rv_decode_pkg::WB_IMM;
            default:             mux_sel_next.wb_src = rv_decode_pkg::WB_ALU;
        endcase
        case (opclass)
            rv_decode_pkg::JAL:    mux_sel_next.pc_src = rv_decode_pkg::PC_PC_REL;
            rv_decode_pkg::JALR:   mux_sel_next.pc_src = rv_decode_pkg::PC_JALR_TARGET;
            rv_decode_pkg::BRANCH: mux_sel_next.pc_src = rv_decode_pkg::PC_BRANCH_COND;
            default:               mux_sel_next.pc_src = rv_decode_pkg::PC_NPC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_read  <= '0;
            alu_ctrl <= '0;
            mem_ctrl <= '0;
            wb_ctrl  <= '0;
            mux_sel  <= '0; // First value of every select
        end else begin
            rf_read  <= rf_read_next;
            alu_ctrl <= alu_ctrl_next;
            mem_ctrl <= mem_ctrl_next;
            wb_ctrl  <= wb_ctrl_next;
            mux_sel  <= mux_sel_next;
        end
    end

    // Memory access always needs the address adder
    mem_needs_alu: assert property (@(posedge clk) disable iff (rst)
        mem_ctrl.enable |-> alu_ctrl.enable)
        else $error("memory stage enabled without ALU");

endmodule

// ==== hdl/rv_decode_top.sv ====
// RV32I instruction decoder top

`timescale 1ns/1ps

module rv_decode_top #(
    parameter int REG_ADDR_W = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_decode_pkg::instr_fields_t instr,
    output logic [31:0]                  imm,
    output rv_decode_pkg::rf_read_t      rf_read,
    output rv_decode_pkg::alu_ctrl_t     alu_ctrl,
    output rv_decode_pkg::mem_ctrl_t     mem_ctrl,
    output rv_decode_pkg::wb_ctrl_t      wb_ctrl,
    output rv_decode_pkg::mux_sel_t      mux_sel,
    output logic                         fault
);

    rv_decode_pkg::opclass_e opclass;

    opcode_classifier u_classifier (
        .instr   (instr),
        .opclass (opclass)
    );

    field_validator #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_validator (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .opclass (opclass),
        .fault   (fault)
    );

    imm_generator u_imm (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .opclass (opclass),
        .imm     (imm)
    );

    microcode_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .opclass  (opclass),
        .rf_read  (rf_read),
        .alu_ctrl (alu_ctrl),
        .mem_ctrl (mem_ctrl),
        .wb_ctrl  (wb_ctrl),
        .mux_sel  (mux_sel)
    );

endmodule

// ==== test/tb_reference.svh ====
// Reference decoder and instruction builders
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

typedef struct packed {
    logic                     fault;
    logic [31:0]              imm;
    rv_decode_pkg::rf_read_t  rf_read;
    rv_decode_pkg::alu_ctrl_t alu_ctrl;
    rv_decode_pkg::mem_ctrl_t mem_ctrl;
    rv_decode_pkg::wb_ctrl_t  wb_ctrl;
    rv_decode_pkg::mux_sel_t  mux_sel;
} exp_t;

function automatic exp_t ref_decode(input logic [31:0] w, input int reg_w);
    exp_t       e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       lui, auipc, jal, jalr, br, ld, st, opi, op, ill;
    int         lim;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    lim   = 1 << reg_w;
    lui   = opc == 7'b0110111;
    auipc = opc == 7'b0010111;
    jal   = opc == 7'b1101111;
    jalr  = opc == 7'b1100111;
    br    = opc == 7'b1100011;
    ld    = opc == 7'b0000011;
    st    = opc == 7'b0100011;
    opi   = opc == 7'b0010011;
    op    = opc == 7'b0110011;
    ill   = !(lui || auipc || jal || jalr || br || ld || st || opi || op);

    e.fault = ill || (st && f3 > 3'd2) || (ld && (f3 == 3'd3 || f3 >= 3'd6))
        || (br && (f3 == 3'd2 || f3 == 3'd3)) || (jalr && f3 != 3'd0)
        || (op && !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
        || (opi && f3 == 3'd1 && f7 != 7'h00)
        || (opi && f3 == 3'd5 && !(f7 == 7'h00 || f7 == 7'h20))
        || ((jalr || br || ld || st || op || opi) && 32'(w[19:15]) >= lim)
        || ((br || st || op) && 32'(w[24:20]) >= lim)
        || (!(br || st) && 32'(w[11:7]) >= lim);

    if (lui || auipc) e.imm = {w[31:12], 12'h000};
    else if (jal)     e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    else if (br)      e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    else if (st)      e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
    else              e.imm = {{20{w[31]}}, w[31:20]};

    e.rf_read.enable  = jalr || br || ld || st || op || opi;
    e.rf_read.rs1     = w[19:15];
    e.rf_read.rs2     = w[24:20];
    e.alu_ctrl.enable = op || opi || br || ld || st || auipc || jalr;
    e.alu_ctrl.branch = br;
    e.alu_ctrl.op     = (op || opi || br) ? f3 : 3'd0;
    e.alu_ctrl.alt    = ((op && (f3 == 3'd0 || f3 == 3'd5)) || (opi && f3 == 3'd5)) && f7[5];
    e.mem_ctrl.enable = ld || st;
    e.mem_ctrl.store  = st;
    e.mem_ctrl.width  = f3;
    e.wb_ctrl.enable  = !(st || br || ill);
    e.wb_ctrl.rd      = w[11:7];
    e.mux_sel.alu_a   = auipc ? rv_decode_pkg::ALU_A_PC : rv_decode_pkg::ALU_A_RS1;
    e.mux_sel.alu_b   = (op || br) ? rv_decode_pkg::ALU_B_RS2 : rv_decode_pkg::ALU_B_IMM;
    if (ld)               e.mux_sel.wb_src = rv_decode_pkg::WB_MEM;
    else if (jal || jalr) e.mux_sel.wb_src = rv_decode_pkg::WB_NPC;
    else if (lui)         e.mux_sel.wb_src = rv_decode_pkg::WB_IMM;
    else                  e.mux_sel.wb_src = rv_decode_pkg::WB_ALU;
    if (jal)       e.mux_sel.pc_src = rv_decode_pkg::PC_PC_REL;
    else if (jalr) e.mux_sel.pc_src = rv_decode_pkg::PC_JALR_TARGET;
    else if (br)   e.mux_sel.pc_src = rv_decode_pkg::PC_BRANCH_COND;
    else           e.mux_sel.pc_src = rv_decode_pkg::PC_NPC;
    return e;
endfunction

function automatic logic [31:0] build_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] build_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] build_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] build_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] build_u(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] build_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

`endif

// ==== test/tb_rv_decode.sv ====
// RV32I decoder testbench

`timescale 1ns/1ps

`include "tb_reference.svh"

module tb_rv_decode;

    localparam int REG_ADDR_W  = 4;
    localparam int STIM_CYCLES = 3100; // Reset, directed, 1000 imm, illegal, 2000 random

    logic                         clk = 1'b0;
    logic                         rst;
    rv_decode_pkg::instr_fields_t instr;
    logic [31:0]                  imm;
    rv_decode_pkg::rf_read_t      rf_read;
    rv_decode_pkg::alu_ctrl_t     alu_ctrl;
    rv_decode_pkg::mem_ctrl_t     mem_ctrl;
    rv_decode_pkg::wb_ctrl_t      wb_ctrl;
    rv_decode_pkg::mux_sel_t      mux_sel;
    logic                         fault;

    logic [31:0] rng_state = 32'h253d;
    logic [31:0] cap_w;
    logic        cap_v = 1'b0;
    logic        stim_on = 1'b0;
    logic        imm_always = 1'b0;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic [6:0]  legal_opc [9] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                   7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011};

    rv_decode_top #(.REG_ADDR_W(REG_ADDR_W)) DUT (
        .clk(clk), .rst(rst), .instr(instr), .imm(imm), .rf_read(rf_read),
        .alu_ctrl(alu_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
        .mux_sel(mux_sel), .fault(fault)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic report_mismatch(input logic [31:0] w, input string field,
            input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH at %0t: instr %h field %s got %h expected %h",
                 $time, w, field, got, exp);
        errors++;
    endtask

    task automatic drive(input logic [31:0] w);
        @(negedge clk);
        instr   = w;
        stim_on = 1'b1;
    endtask

    task automatic end_test(input string name, input int err_before);
        @(negedge clk);
        stim_on = 1'b0;
        repeat (3) @(negedge clk);
        imm_always = 1'b0;
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Word captured on the same edge that registers its decode
    always @(posedge clk) begin
        cap_w <= instr;
        cap_v <= stim_on && !rst;
    end

    always @(negedge clk) begin : compare_outputs
        exp_t e;
        if (cap_v) begin
            e = ref_decode(cap_w, REG_ADDR_W);
            if (fault !== e.fault) report_mismatch(cap_w, "fault", 32'(fault), 32'(e.fault));
            if ((!e.fault || imm_always) && imm !== e.imm)
                report_mismatch(cap_w, "imm", imm, e.imm);
            if (!e.fault) begin
                if (rf_read !== e.rf_read)
                    report_mismatch(cap_w, "rf_read", 32'(rf_read), 32'(e.rf_read));
                if (alu_ctrl !== e.alu_ctrl)
                    report_mismatch(cap_w, "alu_ctrl", 32'(alu_ctrl), 32'(e.alu_ctrl));
                if (mem_ctrl !== e.mem_ctrl)
                    report_mismatch(cap_w, "mem_ctrl", 32'(mem_ctrl), 32'(e.mem_ctrl));
                if (wb_ctrl !== e.wb_ctrl)
                    report_mismatch(cap_w, "wb_ctrl", 32'(wb_ctrl), 32'(e.wb_ctrl));
                if (mux_sel !== e.mux_sel)
                    report_mismatch(cap_w, "mux_sel", 32'(mux_sel), 32'(e.mux_sel));
            end
        end
    end

    initial begin
        #((STIM_CYCLES + 100) * 20);
        $display("Timeout: simulation did not finish within %0d cycles", STIM_CYCLES + 100);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] dir_w [9];
        logic [31:0] bad_w [8];
        logic [31:0] r;
        logic [31:0] r2;
        int          e0;
        rst   = 1'b1;
        instr = '0;

        // Reset state
        e0 = errors;
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (fault !== 1'b0 || rf_read.enable !== 1'b0 || alu_ctrl.enable !== 1'b0 ||
                mem_ctrl.enable !== 1'b0 || wb_ctrl.enable !== 1'b0 || imm !== 32'h0 ||
                mux_sel !== '0) begin
            $display("Reset state wrong at %0t: outputs not cleared", $time);
            errors++;
        end
        rst = 1'b0;
        end_test("reset_state", e0);

        // One legal word per class
        e0 = errors;
        dir_w = '{build_u(20'h12345, 5'd1, 7'b0110111), build_u(20'h80000, 5'd2, 7'b0010111),
                  build_j(21'h1ffff8, 5'd3), build_i(12'd12, 5'd5, 3'd0, 5'd4, 7'b1100111),
                  build_b(13'h1ff0, 5'd2, 5'd1, 3'd1), build_i(12'hffc, 5'd7, 3'd2, 5'd6, 7'b0000011),
                  build_s(12'd20, 5'd9, 5'd8, 3'd2), build_i(12'hfff, 5'd11, 3'd0, 5'd10, 7'b0010011),
                  build_r(7'h20, 5'd14, 5'd13, 3'd0, 5'd12, 7'b0110011)};
        foreach (dir_w[i]) begin
            if (ref_decode(dir_w[i], REG_ADDR_W).fault) begin
                $display("Directed word %h is not legal", dir_w[i]);
                errors++;
            end
            drive(dir_w[i]);
        end
        end_test("directed_legal", e0);

        // Immediate formats under random fields
        e0 = errors;
        imm_always = 1'b1;
        foreach (legal_opc[k]) begin
            if (legal_opc[k] inside {7'b0110111, 7'b1101111, 7'b1100011,
                                     7'b0100011, 7'b0010011}) begin
                repeat (200) begin
                    r = next_rand();
                    drive({r[31:7], legal_opc[k]});
                end
            end
        end
        end_test("imm_formats", e0);

        // Illegal encodings
        e0 = errors;
        bad_w = '{32'h00000073, 32'h0000000f, build_i(12'd1, 5'd1, 3'd0, 5'd1, 7'b0010010),
                  build_s(12'd4, 5'd2, 5'd1, 3'd3), build_i(12'd0, 5'd1, 3'd1, 5'd1, 7'b1100111),
                  build_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd3, 7'b0110011),
                  build_r(7'h20, 5'd3, 5'd1, 3'd1, 5'd2, 7'b0010011),
                  build_i(12'd5, 5'd1, 3'd0, 5'd16, 7'b0010011)};
        foreach (bad_w[i]) begin
            if (!ref_decode(bad_w[i], REG_ADDR_W).fault) begin
                $display("Illegal word %h is not flagged by the reference", bad_w[i]);
                errors++;
            end
            drive(bad_w[i]);
        end
        end_test("illegal_fields", e0);

        // Back-to-back random stream
        e0 = errors;
        repeat (2000) begin
            r  = next_rand();
            r2 = next_rand();
            if (r2[31]) r[6:0] = legal_opc[r2 % 32'd9];
            drive(r);
        end
        end_test("random_stream", e0);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+test
hdl/rv_decode_pkg.sv
hdl/opcode_classifier.sv
hdl/field_validator.sv
hdl/imm_generator.sv
hdl/microcode_encoder.sv
hdl/rv_decode_top.sv
test/tb_rv_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_rv_decode -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
